// ==== Makefile ====
# Verilator build and run of the LED panel testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_led_panel
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
hdl/led_pkg.sv
hdl/wb_pixel_port.sv
hdl/frame_mem.sv
hdl/scan_ctrl.sv
hdl/bitplane_select.sv
hdl/bcm_timer.sv
hdl/led_panel_top.sv
test/tb_led_panel.sv

// ==== hdl/bcm_timer.sv ====
`timescale 1ns/1ps

module bcm_timer
  (input  logic       clk_i,
   input  logic       rst_i,
   input  logic       load_i,
   input  logic [2:0] plane_i,
   output logic       done_o);

  logic [7:0] weight;
  logic [7:0] count;

  ////////////////////////////////////////
  // plane weights
  ////////////////////////////////////////

  always_comb
    case (plane_i)
      3'd7: weight = 8'd255;  // 256 does not fit
      3'd6: weight = 8'd128;
      3'd5: weight = 8'd64;
      3'd4: weight = 8'd32;
      3'd3: weight = 8'd16;
      3'd2: weight = 8'd8;
      3'd1: weight = 8'd4;
      3'd0: weight = 8'd2;
    endcase

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      count <= 8'd0;
    else if (load_i)
      count <= weight;
    else if (count != 8'd0)
      count <= count - 1'b1;

  assign done_o = (count == 8'd0);

  // the FSM only latches once the previous on-time is over
  load_when_idle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    load_i |-> count == 8'd0);

endmodule

// ==== hdl/bitplane_select.sv ====
`timescale 1ns/1ps

module bitplane_select
  (input  logic             clk_i,
   input  logic             rst_i,
   input  led_pkg::pixel_t  pix_i,
   input  logic [2:0]       plane_i,
   input  logic             cap0_i,
   input  logic             cap1_i,
   output led_pkg::rgb_t    rgb0_o,
   output led_pkg::rgb_t    rgb1_o);

  import led_pkg::*;

  rgb_t plane_bits;

  // one bit of each colour level
  always_comb
  begin
    plane_bits.r = pix_i.r[plane_i];
    plane_bits.g = pix_i.g[plane_i];
    plane_bits.b = pix_i.b[plane_i];
  end

  ////////////////////////////////////////
  // shift data registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      rgb0_o <= '0;
      rgb1_o <= '0;
    end
    else
    begin
      if (cap0_i)
        rgb0_o <= plane_bits;  // upper half
      if (cap1_i)
        rgb1_o <= plane_bits;  // lower half
    end

endmodule

// ==== hdl/frame_mem.sv ====
`timescale 1ns/1ps

module frame_mem
  #(parameter int DEPTH = 512)
  (input  logic                       clk_i,
   // bus port, byte-lane writes
   input  logic                       a_we_i,
   input  logic [2:0]                 a_be_i,
   input  logic [$clog2(DEPTH)-1:0]   a_addr_i,
   input  led_pkg::pixel_t            a_wdata_i,
   output led_pkg::pixel_t            a_rdata_o,
   // scan port, read only
   input  logic [$clog2(DEPTH)-1:0]   b_addr_i,
   output led_pkg::pixel_t            b_rdata_o);

  logic [2:0][7:0] mem [DEPTH];  // byte 0 is blue

  ////////////////////////////////////////
  // port a
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (a_we_i)
    begin
      for (int i = 0; i < 3; i++)
      begin
        if (a_be_i[i])
          mem[a_addr_i][i] <= a_wdata_i[i*8 +: 8];
      end
    end
    a_rdata_o <= mem[a_addr_i];  // old data on same-cycle write
  end

  ////////////////////////////////////////
  // port b
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
    b_rdata_o <= mem[b_addr_i];

endmodule

// ==== hdl/led_panel_top.sv ====
`timescale 1ns/1ps

module led_panel_top
  #(parameter int COL = 32,
    parameter int ROW = 16)
  (input  logic               clk_i,
   input  logic               rst_i,
   input  led_pkg::wb_req_t   wb_req_i,
   output led_pkg::wb_rsp_t   wb_rsp_o,
   output led_pkg::panel_o_t  panel_o);

  import led_pkg::*;

  localparam int AW = $clog2(COL*ROW);

  // bus side of the frame buffer
  logic          mem_we;
  logic [2:0]    mem_be;
  logic [AW-1:0] mem_addr;
  pixel_t        mem_wdata;
  pixel_t        mem_rdata;

  // scan side
  logic [AW-1:0] scan_addr;
  pixel_t        scan_pix;
  logic [2:0]    plane;
  logic          cap0, cap1;
  logic          load, done;
  rgb_t          rgb0, rgb1;
  panel_ctl_t    panel_ctl;

  ////////////////////////////////////////
  // bus and memory
  ////////////////////////////////////////

  wb_pixel_port #(.COL(COL), .ROW(ROW)) wb_pixel_port_i
    (.clk_i       (clk_i),
     .rst_i       (rst_i),
     .req_i       (wb_req_i),
     .rsp_o       (wb_rsp_o),
     .mem_we_o    (mem_we),
     .mem_be_o    (mem_be),
     .mem_addr_o  (mem_addr),
     .mem_wdata_o (mem_wdata),
     .mem_rdata_i (mem_rdata));

  frame_mem #(.DEPTH(COL*ROW)) frame_mem_i
    (.clk_i     (clk_i),
     .a_we_i    (mem_we),
     .a_be_i    (mem_be),
     .a_addr_i  (mem_addr),
     .a_wdata_i (mem_wdata),
     .a_rdata_o (mem_rdata),
     .b_addr_i  (scan_addr),
     .b_rdata_o (scan_pix));

  ////////////////////////////////////////
  // scan engine
  ////////////////////////////////////////

  scan_ctrl #(.COL(COL), .ROW(ROW)) scan_ctrl_i
    (.clk_i       (clk_i),
     .rst_i       (rst_i),
     .scan_addr_o (scan_addr),
     .plane_o     (plane),
     .cap0_o      (cap0),
     .cap1_o      (cap1),
     .load_o      (load),
     .done_i      (done),
     .panel_ctl_o (panel_ctl));

  bitplane_select bitplane_select_i
    (.clk_i   (clk_i),
     .rst_i   (rst_i),
     .pix_i   (scan_pix),
     .plane_i (plane),
     .cap0_i  (cap0),
     .cap1_i  (cap1),
     .rgb0_o  (rgb0),
     .rgb1_o  (rgb1));

  bcm_timer bcm_timer_i
    (.clk_i   (clk_i),
     .rst_i   (rst_i),
     .load_i  (load),
     .plane_i (plane),
     .done_o  (done));

  assign panel_o = '{row:  panel_ctl.row,
                     rgb0: rgb0,
                     rgb1: rgb1,
                     lat:  panel_ctl.lat,
                     sclk: panel_ctl.sclk,
                     oe_n: panel_ctl.oe_n};

endmodule

// ==== hdl/led_pkg.sv ====
package led_pkg;

  ////////////////////////////////////////
  // bus bundles
  ////////////////////////////////////////

  // classic pipelined request from the master
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;   // byte address
    logic [3:0]  sel;   // byte enables
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        stall; // tied low
    logic [31:0] dat;
  } wb_rsp_t;

  ////////////////////////////////////////
  // pixel and panel types
  ////////////////////////////////////////

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;      // lowest byte
  } pixel_t;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_t;

  typedef struct packed {
    logic [3:0] row;
    rgb_t       rgb0;   // upper half
    rgb_t       rgb1;   // lower half
    logic       lat;
    logic       sclk;
    logic       oe_n;
  } panel_o_t;

  // control part of the panel bundle, formed by the scan FSM
  typedef struct packed {
    logic [3:0] row;
    logic       lat;
    logic       sclk;
    logic       oe_n;
  } panel_ctl_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ1,
    S_READ2,
    S_CLOCK,
    S_LATCH,
    S_DELAY
  } scan_state_t;

endpackage

// ==== hdl/scan_ctrl.sv ====
`timescale 1ns/1ps

module scan_ctrl
  #(parameter int COL = 32,
    parameter int ROW = 16)
  (input  logic                         clk_i,
   input  logic                         rst_i,
   output logic [$clog2(COL*ROW)-1:0]   scan_addr_o,
   output logic [2:0]                   plane_o,
   output logic                         cap0_o,
   output logic                         cap1_o,
   output logic                         load_o,
   input  logic                         done_i,
   output led_pkg::panel_ctl_t          panel_ctl_o);

  import led_pkg::*;

  localparam int CW = $clog2(COL);
  localparam int RW = $clog2(ROW/2);

  scan_state_t   state, state_next;
  logic [CW-1:0] col, col_next;
  logic          half, half_next;    // 0 upper, 1 lower
  logic [2:0]    plane, plane_next;
  logic [RW-1:0] row, row_next;

  ////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      state <= S_IDLE;
      col   <= '0;
      half  <= 1'b0;
      plane <= 3'd7;   // msb plane first
      row   <= '0;
    end
    else
    begin
      state <= state_next;
      col   <= col_next;
      half  <= half_next;
      plane <= plane_next;
      row   <= row_next;
    end

  always_comb
  begin
    state_next = state;
    col_next   = col;
    half_next  = half;
    plane_next = plane;
    row_next   = row;

    case (state)
      S_IDLE:
      begin
        state_next = S_READ1;
        half_next  = 1'b1;   // lower half address next
      end
      S_READ1:
      begin
        state_next = S_READ2;
        half_next  = 1'b0;
      end
      S_READ2:
        state_next = S_CLOCK;
      S_CLOCK:
        if (col == CW'(COL-1))
        begin
          col_next   = '0;
          state_next = S_LATCH;
        end
        else
        begin
          col_next   = col + 1'b1;
          state_next = S_IDLE;
        end
      S_LATCH:
        state_next = S_DELAY;   // timer loads here
      S_DELAY:
        if (done_i)
        begin
          state_next = S_IDLE;
          plane_next = plane - 1'b1;   // wraps 0 -> 7
          if (plane == 3'd0)
            row_next = (row == RW'(ROW/2-1)) ? '0 : row + 1'b1;
        end
      default:
        state_next = S_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign scan_addr_o = {half, row, col};
  assign plane_o     = plane;
  assign cap0_o      = (state == S_READ1);  // upper pixel on RAM output
  assign cap1_o      = (state == S_READ2);
  assign load_o      = (state == S_LATCH);

  always_comb
  begin
    panel_ctl_o.row  = 4'(row);
    panel_ctl_o.lat  = (state == S_LATCH);
    panel_ctl_o.sclk = (state == S_CLOCK);
    panel_ctl_o.oe_n = (state != S_DELAY);
  end

  // row steps only at the end of the plane 0 on-time
  row_on_plane0: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $changed(row) |-> $past(state == S_DELAY && done_i && plane == 3'd0));

  no_shift_while_lit: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(panel_ctl_o.sclk && !panel_ctl_o.oe_n));

endmodule

// ==== hdl/wb_pixel_port.sv ====
`timescale 1ns/1ps

module wb_pixel_port
  #(parameter int COL = 32,
    parameter int ROW = 16)
  (input  logic                            clk_i,
   input  logic                            rst_i,
   input  led_pkg::wb_req_t                req_i,
   output led_pkg::wb_rsp_t                rsp_o,
   output logic                            mem_we_o,
   output logic [2:0]                      mem_be_o,
   output logic [$clog2(COL*ROW)-1:0]      mem_addr_o,
   output led_pkg::pixel_t                 mem_wdata_o,
   input  led_pkg::pixel_t                 mem_rdata_i);

  import led_pkg::*;

  localparam int AW = $clog2(COL*ROW);

  logic       accept;
  logic [1:0] ack_sr;   // accept delayed by one and two cycles
  pixel_t     rd_data;

  assign accept = req_i.cyc & req_i.stb;

  ////////////////////////////////////////
  // memory bus port
  ////////////////////////////////////////

  assign mem_we_o    = accept & req_i.we;
  assign mem_be_o    = req_i.sel[2:0];     // blue, green, red lanes
  assign mem_addr_o  = req_i.adr[AW+1:2];  // word address
  assign mem_wdata_o = req_i.dat[23:0];

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      ack_sr <= 2'b00;
    else
      ack_sr <= {ack_sr[0], accept};

  // RAM output is valid one cycle after accept, hold it for the ack cycle
  always_ff @(posedge clk_i)
    if (ack_sr[0])
      rd_data <= mem_rdata_i;

  always_comb
  begin
    rsp_o.ack   = ack_sr[1];
    rsp_o.stall = 1'b0;
    rsp_o.dat   = {8'h00, rd_data};  // top byte reads as zero
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  ack_follows_accept: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rsp_o.ack |-> $past(accept, 2));

endmodule

// ==== test/tb_led_panel.sv ====
`timescale 1ns/1ps

module tb_led_panel;

  import led_pkg::*;

  localparam int COL        = 8;
  localparam int ROW        = 4;
  localparam int N_PIX      = COL*ROW;
  localparam int AW         = $clog2(N_PIX);
  localparam int N_SHIFTS   = 2*(ROW/2)*8*COL;  // two frames of columns
  localparam int MAX_CYCLES = 12000;

  logic     clk_i;
  logic     rst_i;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  panel_o_t panel;

  pixel_t   shadow [N_PIX];  // pixels as written by the bus master
  integer   seed = 32'h2314_ae4a;
  int       cycle_cnt = 0;
  logic     fill_done;

  // read response model
  logic [1:0]  acc_pipe;
  logic [1:0]  rd_pipe;
  logic [31:0] exp_dat_d1, exp_dat_d2;
  int          reads_checked;

  // panel model
  logic       sclk_q, oe_n_q;
  int         sclk_cnt, oe_len;
  logic [2:0] exp_plane;
  int         exp_row, exp_next_row, exp_on_time;
  logic       check_data;
  int         frames_seen, shifts_checked;
  rgb_t       exp_rgb0, exp_rgb1;

  led_panel_top #(.COL(COL), .ROW(ROW)) led_panel_top_i
    (.clk_i    (clk_i),
     .rst_i    (rst_i),
     .wb_req_i (wb_req),
     .wb_rsp_o (wb_rsp),
     .panel_o  (panel));

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [AW-1:0] pix_index(input logic half, input int row, input int col);
    return AW'((int'(half)*(ROW/2) + row)*COL + col);
  endfunction

  function automatic rgb_t plane_bits(input pixel_t pix, input logic [2:0] plane);
    rgb_t bits;
    bits.r = pix.r[plane];
    bits.g = pix.g[plane];
    bits.b = pix.b[plane];
    return bits;
  endfunction

  // on-time in cycles is the weight plus one
  function automatic int on_time(input logic [2:0] plane);
    if (plane == 3'd7)
      return 256;
    return (1 << (int'(plane) + 1)) + 1;
  endfunction

  function automatic wb_req_t make_req(input logic we, input int idx, input logic [3:0] sel,
                                       input logic [31:0] dat);
    wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = 32'(idx) << 2;
    req.sel = sel;
    req.dat = dat;
    return req;
  endfunction

  task automatic write_frame(input logic partial);
    logic [31:0] dat;
    logic [3:0]  sel;
    int          i;
    int          b;
    for (i = 0; i < N_PIX; i++)
    begin
      dat = $random(seed);
      sel = partial ? 4'($random(seed)) : 4'hf;
      @(posedge clk_i);
      wb_req <= make_req(1'b1, i, sel, dat);
      for (b = 0; b < 3; b++)
        if (sel[b])
          shadow[AW'(i)][b*8 +: 8] = dat[b*8 +: 8];  // lane 3 ignored
    end
    @(posedge clk_i);
    wb_req <= '0;
  endtask

  task automatic read_frame();
    int i;
    for (i = 0; i < N_PIX; i++)
    begin
      @(posedge clk_i);
      wb_req <= make_req(1'b0, i, 4'hf, 32'h0);
    end
    @(posedge clk_i);
    wb_req <= '0;
    repeat (4) @(posedge clk_i);  // drain the last acks
  endtask

  ////////////////////////////////////////
  // reference models
  ////////////////////////////////////////

  always @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      acc_pipe      <= 2'b00;
      rd_pipe       <= 2'b00;
      reads_checked <= 0;
    end
    else
    begin
      acc_pipe   <= {acc_pipe[0], wb_req.cyc && wb_req.stb};
      rd_pipe    <= {rd_pipe[0], wb_req.cyc && wb_req.stb && !wb_req.we};
      exp_dat_d1 <= {8'h00, shadow[wb_req.adr[AW+1:2]]};
      exp_dat_d2 <= exp_dat_d1;
      if (rd_pipe[1])
        reads_checked <= reads_checked + 1;
    end

  assign exp_on_time  = on_time(exp_plane);
  assign exp_next_row = (exp_row == ROW/2 - 1) ? 0 : exp_row + 1;
  assign exp_rgb0     = plane_bits(shadow[pix_index(1'b0, exp_row, sclk_cnt)], exp_plane);
  assign exp_rgb1     = plane_bits(shadow[pix_index(1'b1, exp_row, sclk_cnt)], exp_plane);

  always @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      sclk_q         <= 1'b0;
      oe_n_q         <= 1'b1;
      sclk_cnt       <= 0;
      oe_len         <= 0;
      exp_plane      <= 3'd7;
      exp_row        <= 0;
      check_data     <= 1'b0;
      frames_seen    <= 0;
      shifts_checked <= 0;
    end
    else
    begin
      sclk_q <= panel.sclk;
      oe_n_q <= panel.oe_n;
      if (panel.lat)
        sclk_cnt <= 0;
      else if (panel.sclk && !sclk_q)
        sclk_cnt <= sclk_cnt + 1;
      if (check_data && panel.sclk && !sclk_q)
        shifts_checked <= shifts_checked + 1;
      oe_len <= panel.oe_n ? 0 : oe_len + 1;
      if (panel.oe_n && !oe_n_q)  // end of an on-time
      begin
        exp_plane <= exp_plane - 3'd1;
        if (exp_plane == 3'd0)
        begin
          exp_row <= exp_next_row;
          if (exp_row == ROW/2 - 1)  // frame boundary
          begin
            if (check_data)
              frames_seen <= frames_seen + 1;
            if (fill_done)
              check_data <= 1'b1;
          end
        end
      end
    end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  reset_outputs: assert property (@(posedge clk_i)
    (rst_i || $past(rst_i)) |-> !panel.lat && !panel.sclk && !wb_rsp.ack && panel.oe_n)
    else fail_run("Panel or bus outputs were not idle during or right after reset");

  ack_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_rsp.ack == acc_pipe[1])
    else fail_run($sformatf("Error: wb_rsp_o.ack = %h, expected %h",
                            $sampled(wb_rsp.ack), $sampled(acc_pipe[1])));

  stall_low: assert property (@(posedge clk_i) disable iff (rst_i)
    !wb_rsp.stall)
    else fail_run("Error: wb_rsp_o.stall = 1, expected 0");

  read_data: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_pipe[1] |-> wb_rsp.dat == exp_dat_d2)
    else fail_run($sformatf("Error: wb_rsp_o.dat = %h, expected %h",
                            $sampled(wb_rsp.dat), $sampled(exp_dat_d2)));

  shift_count: assert property (@(posedge clk_i) disable iff (rst_i)
    panel.lat |-> sclk_cnt == COL)
    else fail_run($sformatf("Error: sclk pulse count = %h, expected %h",
                            $sampled(sclk_cnt), COL));

  no_shift_lit: assert property (@(posedge clk_i) disable iff (rst_i)
    !(panel.sclk && !panel.oe_n))
    else fail_run("Shift clock pulsed while the LEDs were enabled");

  oe_after_lat: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(panel.lat) |-> !panel.oe_n)
    else fail_run("Output enable did not go active after a latch");

  oe_needs_lat: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(panel.oe_n) |-> $past(panel.lat))
    else fail_run("Output enable went active without a preceding latch");

  plane_on_time: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(panel.oe_n) |-> oe_len == exp_on_time)
    else fail_run($sformatf("Error: oe_n low cycles = %h, expected %h",
                            $sampled(oe_len), $sampled(exp_on_time)));

  row_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    $changed(panel.row) |-> $rose(panel.oe_n) && exp_plane == 3'd0)
    else fail_run("Row address changed outside the end of a plane 0 on-time");

  row_step: assert property (@(posedge clk_i) disable iff (rst_i)
    ($rose(panel.oe_n) && exp_plane == 3'd0) |-> int'(panel.row) == exp_next_row)
    else fail_run($sformatf("Error: panel_o.row = %h, expected %h",
                            $sampled(panel.row), $sampled(exp_next_row)));

  row_at_lat: assert property (@(posedge clk_i) disable iff (rst_i)
    panel.lat |-> int'(panel.row) == exp_row)
    else fail_run($sformatf("Error: panel_o.row = %h, expected %h",
                            $sampled(panel.row), $sampled(exp_row)));

  upper_data: assert property (@(posedge clk_i) disable iff (rst_i)
    (check_data && panel.sclk && !sclk_q) |-> panel.rgb0 == exp_rgb0)
    else fail_run($sformatf("Error: panel_o.rgb0 = %h, expected %h",
                            $sampled(panel.rgb0), $sampled(exp_rgb0)));

  lower_data: assert property (@(posedge clk_i) disable iff (rst_i)
    (check_data && panel.sclk && !sclk_q) |-> panel.rgb1 == exp_rgb1)
    else fail_run($sformatf("Error: panel_o.rgb1 = %h, expected %h",
                            $sampled(panel.rgb1), $sampled(exp_rgb1)));

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES)
      fail_run("Timeout: the run did not finish within the cycle limit");
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    rst_i     <= 1'b1;
    wb_req    <= '0;
    fill_done <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    write_frame(1'b0);  // full words
    write_frame(1'b1);  // random byte enables
    fill_done <= 1'b1;
    read_frame();
    while (frames_seen < 2)
      @(posedge clk_i);
    if (reads_checked == N_PIX && shifts_checked >= N_SHIFTS)
    begin
      $display("Test passed");
      $finish;
    end
    else
      fail_run("Not every read response or shifted column was checked");
  end

endmodule
